//--- include/chip_defines.svh
// chip pad frame build constants
// pad counts, word widths and power-on timing
`ifndef CHIP_DEFINES_SVH
`define CHIP_DEFINES_SVH

//////////////////////////////////////////////////
// pad geometry
//////////////////////////////////////////////////

// width of each GPIO pad word
`define CHIP_GPIO_W 32

// multiplexed pads seen by the core
`define CHIP_MIO_PADS 22

//////////////////////////////////////////////////
// power-on sequencing
//////////////////////////////////////////////////

// supply model sequence counter, saturates at all ones
`define CHIP_SEQ_W 4

// consecutive supply-high samples before reset release
`define CHIP_POK_STABLE 6

//////////////////////////////////////////////////
// input path
//////////////////////////////////////////////////

// flops in the pad input synchroniser
`define CHIP_SYNC_STAGES 2

`endif

//--- design/chip_pkg.sv
// chip pad frame shared types
// MIO pad index map, GPIO word views and core-side bundles
`default_nettype none

`include "chip_defines.svh"

package chip_pkg;

  //////////////////////////////////////////////////
  // MIO pad index map
  //////////////////////////////////////////////////

  // positions in the core MIO vectors, counting up from 0
  typedef enum logic [$clog2(`CHIP_MIO_PADS)-1:0] {
    // generic GPIOs, 0 to 13
    MIO_GPIO_0, MIO_GPIO_1, MIO_GPIO_2, MIO_GPIO_3,
    MIO_GPIO_4, MIO_GPIO_5, MIO_GPIO_6, MIO_GPIO_7,
    MIO_GPIO_8, MIO_GPIO_9, MIO_GPIO_10, MIO_GPIO_11,
    MIO_GPIO_12, MIO_GPIO_13,
    // software straps, 14 to 16
    MIO_SW_STRAP_0, MIO_SW_STRAP_1, MIO_SW_STRAP_2,
    // tap straps
    MIO_TAP_STRAP_0,
    MIO_TAP_STRAP_1,
    // uart and usb
    MIO_UART_RX,
    MIO_UART_TX,
    MIO_USB_SENSE
  } mio_pad_e;

  // pad pull attributes
  typedef struct packed {
    logic pull_en;
    logic pull_select;
  } pad_attr_t;

  //////////////////////////////////////////////////
  // GPIO pad word
  //////////////////////////////////////////////////

  // named pin groups, msb first
  typedef struct packed {
    logic       rsvd3;
    logic       tap_strap0;
    logic [1:0] rsvd2;
    logic       tap_strap1;
    logic [1:0] rsvd1;
    logic [2:0] sw_strap;
    logic [7:0] rsvd0;
    logic [6:0] gen_hi;
    logic [6:0] gen_lo;
  } gpio_fields_t;

  // one GPIO word, read flat or by pin group
  typedef union packed {
    logic [`CHIP_GPIO_W-1:0] raw;
    gpio_fields_t            fields;
  } gpio_word_u;

  // core outputs towards the pads
  typedef struct packed {
    logic [`CHIP_MIO_PADS-1:0]      out;
    logic [`CHIP_MIO_PADS-1:0]      oe;
    pad_attr_t [`CHIP_MIO_PADS-1:0] attr;
  } mio_core_t;

  // pad-side GPIO drive words
  typedef struct packed {
    gpio_word_u d2p;
    gpio_word_u en;
    gpio_word_u pull_en;
    gpio_word_u pull_select;
  } gpio_pad_out_t;

endpackage

`default_nettype wire

//--- design/por_supply_seq.sv
// supply rail model for power-on
// rises, glitches low once, then stays high
`timescale 1ns/1ns
`default_nettype none

`include "chip_defines.svh"

module por_supply_seq (
  input  logic clk_aon,
  input  logic arst_n_i,
  output logic vcc_supp_o
);

  // glitch window edges in sequence counts
  localparam logic [`CHIP_SEQ_W-1:0] RISE_CNT   = `CHIP_SEQ_W'(4);
  localparam logic [`CHIP_SEQ_W-1:0] GLITCH_CNT = `CHIP_SEQ_W'(8);
  localparam logic [`CHIP_SEQ_W-1:0] RECOV_CNT  = `CHIP_SEQ_W'(12);
  localparam logic [`CHIP_SEQ_W-1:0] SEQ_MAX    = '1;

  logic [`CHIP_SEQ_W-1:0] seq_cnt;

  // count up until saturation
  always_ff @(posedge clk_aon or negedge arst_n_i) begin
    if (!arst_n_i) begin
      seq_cnt <= '0;
    end else if (seq_cnt != SEQ_MAX) begin
      seq_cnt <= seq_cnt + 1'b1;
    end
  end

  // low, high, glitch low, then high for good
  always_comb begin
    if (seq_cnt < RISE_CNT) begin
      vcc_supp_o = 1'b0;
    end else if (seq_cnt < GLITCH_CNT) begin
      vcc_supp_o = 1'b1;
    end else if (seq_cnt < RECOV_CNT) begin
      vcc_supp_o = 1'b0;
    end else begin
      vcc_supp_o = 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // a saturated sequence holds the supply up
  sat_supply_high_a: assert property (
    @(posedge clk_aon) disable iff (!arst_n_i)
    (seq_cnt == SEQ_MAX) |=> (seq_cnt == SEQ_MAX) && vcc_supp_o
  ) else $error("supply model left its final high state");

endmodule

`default_nettype wire

//--- design/pok_filter.sv
// power-ok filter
// releases the power-on reset after a stable supply run
`timescale 1ns/1ns
`default_nettype none

`include "chip_defines.svh"

module pok_filter (
  input  logic clk_aon,
  input  logic arst_n_i,
  input  logic vcc_supp_i,
  output logic por_n_o
);

  localparam int unsigned CNT_W = $clog2(`CHIP_POK_STABLE + 1);
  localparam logic [CNT_W-1:0] STABLE = CNT_W'(`CHIP_POK_STABLE);

  logic [CNT_W-1:0] stable_cnt;
  logic [CNT_W-1:0] stable_cnt_nxt;

  // run length of high samples, held at the threshold
  always_comb begin
    if (!vcc_supp_i) begin
      stable_cnt_nxt = '0;
    end else if (stable_cnt == STABLE) begin
      stable_cnt_nxt = STABLE;
    end else begin
      stable_cnt_nxt = stable_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk_aon or negedge arst_n_i) begin
    if (!arst_n_i) begin
      stable_cnt <= '0;
      por_n_o    <= 1'b0;
    end else begin
      stable_cnt <= stable_cnt_nxt;
      // sticky release, a later supply dip does not re-assert reset
      if (stable_cnt_nxt == STABLE) begin
        por_n_o <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // released reset stays released
  por_sticky_a: assert property (
    @(posedge clk_aon) disable iff (!arst_n_i)
    por_n_o |=> por_n_o
  ) else $error("power-on reset re-asserted without external reset");

endmodule

`default_nettype wire

//--- design/pad_in_sync.sv
// pad input path
// maps GPIO and uart rx pins onto MIO core inputs, then synchronises
`timescale 1ns/1ns
`default_nettype none

`include "chip_defines.svh"

module pad_in_sync
  import chip_pkg::*;
(
  input  logic                      clk_aon,
  input  logic                      arst_n_i,
  input  gpio_word_u                gpio_p2d_i,
  input  logic                      uart_rx_i,
  output logic [`CHIP_MIO_PADS-1:0] mio_in_o
);

  logic [`CHIP_MIO_PADS-1:0] mio_map;

  // one row per synchroniser stage, row 0 takes the pads
  logic [`CHIP_SYNC_STAGES-1:0][`CHIP_MIO_PADS-1:0] sync_q;

  //////////////////////////////////////////////////
  // pad to MIO map
  //////////////////////////////////////////////////

  always_comb begin
    mio_map = '0;

    // generic GPIOs
    mio_map[MIO_GPIO_6:MIO_GPIO_0]  = gpio_p2d_i.fields.gen_lo;
    mio_map[MIO_GPIO_13:MIO_GPIO_7] = gpio_p2d_i.fields.gen_hi;

    // software straps
    mio_map[MIO_SW_STRAP_2:MIO_SW_STRAP_0] = gpio_p2d_i.fields.sw_strap;

    // tap straps cross over, bit 30 feeds strap 0
    mio_map[MIO_TAP_STRAP_0] = gpio_p2d_i.fields.tap_strap0;
    mio_map[MIO_TAP_STRAP_1] = gpio_p2d_i.fields.tap_strap1;

    mio_map[MIO_UART_RX] = uart_rx_i;

    // no vbus sense pin on this frame
    mio_map[MIO_USB_SENSE] = 1'b0;
  end

  //////////////////////////////////////////////////
  // synchroniser
  //////////////////////////////////////////////////

  always_ff @(posedge clk_aon or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q <= '0;
    end else begin
      sync_q[0] <= mio_map;
      for (int i = 1; i < `CHIP_SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign mio_in_o = sync_q[`CHIP_SYNC_STAGES-1];

endmodule

`default_nettype wire

//--- design/pad_out_map.sv
// pad output path
// maps MIO core outputs and pull attributes onto GPIO and uart tx pads
`timescale 1ns/1ns
`default_nettype none

`include "chip_defines.svh"

module pad_out_map
  import chip_pkg::*;
(
  input  logic          por_n_i,
  input  mio_core_t     mio_core_i,
  output gpio_pad_out_t gpio_o,
  output logic          uart_tx_o,
  output logic          uart_tx_en_o
);

  logic [`CHIP_MIO_PADS-1:0] pull_en_vec;
  logic [`CHIP_MIO_PADS-1:0] pull_sel_vec;
  gpio_pad_out_t             gpio_map;

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  // place one bit per MIO pad into its GPIO word position
  function automatic gpio_word_u map_word(logic [`CHIP_MIO_PADS-1:0] pad_bits);
    gpio_word_u w;
    // reserved groups stay low
    w.raw               = '0;
    w.fields.gen_lo     = pad_bits[MIO_GPIO_6:MIO_GPIO_0];
    w.fields.gen_hi     = pad_bits[MIO_GPIO_13:MIO_GPIO_7];
    w.fields.sw_strap   = pad_bits[MIO_SW_STRAP_2:MIO_SW_STRAP_0];
    w.fields.tap_strap0 = pad_bits[MIO_TAP_STRAP_0];
    w.fields.tap_strap1 = pad_bits[MIO_TAP_STRAP_1];
    return w;
  endfunction

  // any reserved bit set in a word
  function automatic logic rsvd_any(gpio_word_u w);
    return |{w.fields.rsvd3, w.fields.rsvd2, w.fields.rsvd1, w.fields.rsvd0};
  endfunction

  //////////////////////////////////////////////////
  // mapping
  //////////////////////////////////////////////////

  // split the attribute array into flat pull vectors
  always_comb begin
    for (int i = 0; i < `CHIP_MIO_PADS; i++) begin
      pull_en_vec[i]  = mio_core_i.attr[i].pull_en;
      pull_sel_vec[i] = mio_core_i.attr[i].pull_select;
    end
  end

  always_comb begin
    gpio_map.d2p         = map_word(mio_core_i.out);
    gpio_map.en          = map_word(mio_core_i.oe);
    gpio_map.pull_en     = map_word(pull_en_vec);
    gpio_map.pull_select = map_word(pull_sel_vec);
  end

  // pads stay quiet until power-on reset is released
  assign gpio_o       = por_n_i ? gpio_map : '0;
  assign uart_tx_o    = por_n_i & mio_core_i.out[MIO_UART_TX];
  assign uart_tx_en_o = por_n_i & mio_core_i.oe[MIO_UART_TX];

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // reserved pad bits are never driven, gated or not
  always_comb begin
    rsvd_zero_a: assert final (
      !rsvd_any(gpio_o.d2p) && !rsvd_any(gpio_o.en) &&
      !rsvd_any(gpio_o.pull_en) && !rsvd_any(gpio_o.pull_select)
    ) else $error("reserved GPIO pad bits driven");
  end

endmodule

`default_nettype wire

//--- design/chip_pad_frame.sv
// chip pad and power-on frame
// supply model, power-ok filter and the GPIO/uart pad maps
`timescale 1ns/1ns
`default_nettype none

`include "chip_defines.svh"

module chip_pad_frame
  import chip_pkg::*;
(
  input  logic                      clk_aon,
  input  logic                      arst_n_i,
  // pad side inputs
  input  gpio_word_u                gpio_p2d_i,
  input  logic                      uart_rx_i,
  // core side
  input  mio_core_t                 mio_core_i,
  output logic [`CHIP_MIO_PADS-1:0] mio_in_o,
  // pad side outputs
  output gpio_pad_out_t             gpio_o,
  output logic                      uart_tx_o,
  output logic                      uart_tx_en_o,
  output logic                      por_n_o
);

  logic vcc_supp;
  logic por_n;

  //////////////////////////////////////////////////
  // power-on
  //////////////////////////////////////////////////

  por_supply_seq i_por_supply_seq (
    .clk_aon    (clk_aon),
    .arst_n_i   (arst_n_i),
    .vcc_supp_o (vcc_supp)
  );

  pok_filter i_pok_filter (
    .clk_aon    (clk_aon),
    .arst_n_i   (arst_n_i),
    .vcc_supp_i (vcc_supp),
    .por_n_o    (por_n)
  );

  assign por_n_o = por_n;

  //////////////////////////////////////////////////
  // pads
  //////////////////////////////////////////////////

  pad_in_sync i_pad_in_sync (
    .clk_aon    (clk_aon),
    .arst_n_i   (arst_n_i),
    .gpio_p2d_i (gpio_p2d_i),
    .uart_rx_i  (uart_rx_i),
    .mio_in_o   (mio_in_o)
  );

  // outputs held low by the power-on reset
  pad_out_map i_pad_out_map (
    .por_n_i      (por_n),
    .mio_core_i   (mio_core_i),
    .gpio_o       (gpio_o),
    .uart_tx_o    (uart_tx_o),
    .uart_tx_en_o (uart_tx_en_o)
  );

endmodule

`default_nettype wire

//--- dv/tb_chip_pad_frame.sv
// testbench for the chip pad frame
// random pad and core stimulus checked against a cycle model of power-on and pad maps
`timescale 1ns/1ns
`default_nettype none

`include "chip_defines.svh"

module tb_chip_pad_frame
  import chip_pkg::*;
();

  localparam int RST_CYCLES  = 10;
  localparam int POR_CYCLES  = 30;
  localparam int RAND_CYCLES = 600;
  // reset, power-on and both random phases, with margin
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int SEQ_MAX = (1 << `CHIP_SEQ_W) - 1;
  // rsvd3, rsvd2, rsvd1 and rsvd0 bit positions
  localparam logic [31:0] RSVD_MASK = 32'hB63F_C000;

  logic                      clk_aon;
  logic                      arst_n_i;
  gpio_word_u                gpio_p2d_i;
  logic                      uart_rx_i;
  mio_core_t                 mio_core_i;
  logic [`CHIP_MIO_PADS-1:0] mio_in_o;
  gpio_pad_out_t             gpio_o;
  logic                      uart_tx_o;
  logic                      uart_tx_en_o;
  logic                      por_n_o;

  // reference model state
  int                        seq_m;
  int                        stable_m;
  logic                      por_m;
  logic [`CHIP_MIO_PADS-1:0] sync0_m;
  logic [`CHIP_MIO_PADS-1:0] sync1_m;

  int cycle_cnt;
  bit failed;

  chip_pad_frame i_chip_pad_frame (
    .clk_aon      (clk_aon),
    .arst_n_i     (arst_n_i),
    .gpio_p2d_i   (gpio_p2d_i),
    .uart_rx_i    (uart_rx_i),
    .mio_core_i   (mio_core_i),
    .mio_in_o     (mio_in_o),
    .gpio_o       (gpio_o),
    .uart_tx_o    (uart_tx_o),
    .uart_tx_en_o (uart_tx_en_o),
    .por_n_o      (por_n_o)
  );

  always #10 clk_aon = ~clk_aon;

  always @(posedge clk_aon) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("ERROR: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("SOME TESTS FAILED");
      $fatal(1, "simulation timed out");
    end
  end

  //////////////////////////////////////////////////
  // reference maps
  //////////////////////////////////////////////////

  // GPIO bit that carries a given MIO pad, -1 if none
  function automatic int gpio_bit_of(int pad);
    if (pad < 14) return pad;
    if (pad < 17) return 22 + (pad - 14);
    if (pad == 17) return 30;
    if (pad == 18) return 27;
    return -1;
  endfunction

  function automatic logic [31:0] expected_word(logic [`CHIP_MIO_PADS-1:0] pads);
    logic [31:0] w;
    w = '0;
    for (int p = 0; p < 19; p++) begin
      w[gpio_bit_of(p)] = pads[p];
    end
    return w;
  endfunction

  function automatic logic [`CHIP_MIO_PADS-1:0] expected_mio_in(logic [31:0] g, logic rx);
    logic [`CHIP_MIO_PADS-1:0] v;
    v = '0;
    for (int p = 0; p < 19; p++) begin
      v[p] = g[gpio_bit_of(p)];
    end
    v[19] = rx;
    return v;
  endfunction

  // low, high, glitch low, high
  function automatic logic supply_level(int seq);
    return (seq >= 4 && seq < 8) || seq >= 12;
  endfunction

  //////////////////////////////////////////////////
  // model, checks and cycle driver
  //////////////////////////////////////////////////

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      failed = 1'b1;
      $display("FAIL %s expected %0h actual %0h", name, exp, act);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // one clock edge of the model, inputs are still the values the DUT samples
  task automatic step_model();
    int stable_nxt;
    if (!arst_n_i) begin
      seq_m    = 0;
      stable_m = 0;
      por_m    = 1'b0;
      sync0_m  = '0;
      sync1_m  = '0;
    end else begin
      stable_nxt = !supply_level(seq_m) ? 0 :
                   (stable_m == `CHIP_POK_STABLE) ? stable_m : stable_m + 1;
      if (stable_nxt == `CHIP_POK_STABLE) por_m = 1'b1;
      stable_m = stable_nxt;
      if (seq_m != SEQ_MAX) seq_m = seq_m + 1;
      sync1_m = sync0_m;
      sync0_m = expected_mio_in(gpio_p2d_i.raw, uart_rx_i);
    end
  endtask

  task automatic check_outputs(input string phase);
    logic [`CHIP_MIO_PADS-1:0] pe;
    logic [`CHIP_MIO_PADS-1:0] ps;
    for (int i = 0; i < `CHIP_MIO_PADS; i++) begin
      pe[i] = mio_core_i.attr[i].pull_en;
      ps[i] = mio_core_i.attr[i].pull_select;
    end
    compare({phase, "/por_n"}, 32'(por_m), 32'(por_n_o));
    compare({phase, "/d2p"}, por_m ? expected_word(mio_core_i.out) : '0, gpio_o.d2p.raw);
    compare({phase, "/en"}, por_m ? expected_word(mio_core_i.oe) : '0, gpio_o.en.raw);
    compare({phase, "/pull_en"}, por_m ? expected_word(pe) : '0, gpio_o.pull_en.raw);
    compare({phase, "/pull_sel"}, por_m ? expected_word(ps) : '0, gpio_o.pull_select.raw);
    compare({phase, "/rsvd"}, '0, (gpio_o.d2p.raw | gpio_o.en.raw | gpio_o.pull_en.raw |
                                   gpio_o.pull_select.raw) & RSVD_MASK);
    compare({phase, "/uart_tx"}, 32'(por_m & mio_core_i.out[20]), 32'(uart_tx_o));
    compare({phase, "/uart_tx_en"}, 32'(por_m & mio_core_i.oe[20]), 32'(uart_tx_en_o));
    compare({phase, "/mio_in"}, 32'(sync1_m), 32'(mio_in_o));
    compare({phase, "/usb_sense"}, '0, 32'(mio_in_o[21]));
  endtask

  // drive on the rising edge, check at the falling edge
  task automatic run_cycle(input string phase, input bit new_core, input bit new_pads,
                           input bit rst_n);
    logic [95:0] rnd;
    @(posedge clk_aon);
    step_model();
    arst_n_i <= rst_n;
    if (new_core) begin
      rnd = {$urandom(), $urandom(), $urandom()};
      mio_core_i <= rnd[$bits(mio_core_t)-1:0];
    end
    if (new_pads) begin
      rnd[31:0] = $urandom();
      gpio_p2d_i.raw <= rnd[31:0];
      rnd[63:32] = $urandom();
      uart_rx_i <= rnd[32];
    end
    @(negedge clk_aon);
    check_outputs(phase);
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    clk_aon    = 1'b0;
    arst_n_i   = 1'b0;
    gpio_p2d_i = '0;
    uart_rx_i  = 1'b0;
    mio_core_i = '0;
    seq_m      = 0;
    stable_m   = 0;
    por_m      = 1'b0;
    sync0_m    = '0;
    sync1_m    = '0;
    cycle_cnt  = 0;
    failed     = 1'b0;
    void'($urandom(32'he78ab526));

    repeat (RST_CYCLES) run_cycle("reset", 1'b1, 1'b1, 1'b0);

    // supply glitch, then release, outputs gated until then
    repeat (POR_CYCLES) run_cycle("por_gating", 1'b1, 1'b0, 1'b1);
    compare("por_release", 32'd1, 32'(por_n_o));

    repeat (RAND_CYCLES) run_cycle("out_map", 1'b1, 1'b0, 1'b1);
    repeat (RAND_CYCLES) run_cycle("in_map", 1'b0, 1'b1, 1'b1);

    if (!failed) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("SOME TESTS FAILED");
      $fatal(1, "checks reported mismatches");
    end
  end

endmodule

`default_nettype wire

//--- chip_pad_frame.f
+incdir+include
design/chip_pkg.sv
design/por_supply_seq.sv
design/pok_filter.sv
design/pad_in_sync.sv
design/pad_out_map.sv
design/chip_pad_frame.sv
dv/tb_chip_pad_frame.sv
